//--- common/soc_pkg.sv
package soc_pkg;

    // ====================
    // Bus widths
    // ====================
    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;
    localparam int SEL_W  = DATA_W / 8;
    localparam int OFS_W  = 12;

    // Interrupt priority, 0 never fires
    localparam int PRIO_W = 3;

    // Wishbone classic request from the master
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Slave reply, dat only meaningful with ack
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // Target region, one 4 KiB window each
    typedef enum logic [1:0] {
        SEL_CLINT = 2'd0,
        SEL_PLIC  = 2'd1,
        SEL_GPIO  = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // ====================
    // Register offsets
    // ====================
    // CLINT
    localparam logic [OFS_W-1:0] MSIP_OFS     = 12'h000;
    localparam logic [OFS_W-1:0] MTIMECMP_OFS = 12'h100;
    localparam logic [OFS_W-1:0] MTIME_OFS    = 12'h1F8;

    // PLIC
    localparam logic [OFS_W-1:0] PRIO_OFS     = 12'h000;
    localparam logic [OFS_W-1:0] PEND_OFS     = 12'h080;
    localparam logic [OFS_W-1:0] ENABLE_OFS   = 12'h100;
    localparam logic [OFS_W-1:0] THRESH_OFS   = 12'h200;
    localparam logic [OFS_W-1:0] CLAIM_OFS    = 12'h204;

    // GPIO
    localparam logic [OFS_W-1:0] OUT_OFS      = 12'h000;
    localparam logic [OFS_W-1:0] IN_OFS       = 12'h004;
    localparam logic [OFS_W-1:0] IRQ_MASK_OFS = 12'h008;

    // Byte lane merge of a write into an old word
    function automatic logic [DATA_W-1:0] wb_merge(
        input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] new_w,
        input logic [SEL_W-1:0]  sel
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

//--- src/wb_addr_decode.sv
`timescale 1ns/100ps

module wb_addr_decode (
    input  logic             clk_i,
    input  logic             rst_i,
    input  soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t rsp_o,
    output soc_pkg::wb_req_t clint_req_o,
    output soc_pkg::wb_req_t plic_req_o,
    output soc_pkg::wb_req_t gpio_req_o,
    input  soc_pkg::wb_rsp_t clint_rsp_i,
    input  soc_pkg::wb_rsp_t plic_rsp_i,
    input  soc_pkg::wb_rsp_t gpio_rsp_i
);
    import soc_pkg::*;

    slave_sel_e region;
    logic       err_q;

    // ====================
    // Region decode
    // ====================
    // Top nibble picks the 4 KiB window
    always_comb begin
        case (req_i.adr[ADDR_W-1:OFS_W])
            4'h0:    region = SEL_CLINT;
            4'h1:    region = SEL_PLIC;
            4'h2:    region = SEL_GPIO;
            default: region = SEL_NONE;
        endcase
    end

    // Shared fields, strobe only to the selected slave
    always_comb begin
        clint_req_o     = req_i;
        plic_req_o      = req_i;
        gpio_req_o      = req_i;
        clint_req_o.stb = req_i.stb && (region == SEL_CLINT);
        plic_req_o.stb  = req_i.stb && (region == SEL_PLIC);
        gpio_req_o.stb  = req_i.stb && (region == SEL_GPIO);
    end

    // ====================
    // Unmapped reply
    // ====================
    // One cycle err, same latency as a slave ack
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i.cyc && req_i.stb && (region == SEL_NONE) && !err_q;
        end
    end

    // ====================
    // Response merge
    // ====================
    always_comb begin
        rsp_o.ack = clint_rsp_i.ack | plic_rsp_i.ack | gpio_rsp_i.ack;
        rsp_o.err = err_q | clint_rsp_i.err | plic_rsp_i.err | gpio_rsp_i.err;
        // Data gated by its own ack, error data stays zero
        rsp_o.dat = ({DATA_W{clint_rsp_i.ack}} & clint_rsp_i.dat)
                  | ({DATA_W{plic_rsp_i.ack}}  & plic_rsp_i.dat)
                  | ({DATA_W{gpio_rsp_i.ack}}  & gpio_rsp_i.dat);
    end

    // Single outstanding request means a single reply source
    a_one_reply: assert property (@(posedge clk_i) disable iff (!rst_i)
        $onehot0({clint_rsp_i.ack, plic_rsp_i.ack, gpio_rsp_i.ack, err_q}));

    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(rsp_o.ack && rsp_o.err));

endmodule

//--- clint/soc_clint.sv
`timescale 1ns/100ps

module soc_clint #(
    parameter int HART_NUM = 2
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  soc_pkg::wb_req_t    req_i,
    output soc_pkg::wb_rsp_t    rsp_o,
    output logic [HART_NUM-1:0] timer_irq_o,
    output logic [HART_NUM-1:0] ipi_o
);
    import soc_pkg::*;

    logic                rtc;
    logic [63:0]         mtime;
    logic [63:0]         mtimecmp [HART_NUM];
    logic [HART_NUM-1:0] msip;
    logic                ack_q;
    logic [DATA_W-1:0]   rdata;
    logic [DATA_W-1:0]   rdata_q;
    logic [OFS_W-1:0]    ofs;
    logic                req_hit;
    logic                wr_hit;

    assign ofs     = req_i.adr[OFS_W-1:0];
    // New access only when no reply is pending
    assign req_hit = req_i.cyc && req_i.stb && !ack_q;
    assign wr_hit  = req_hit && req_i.we;

    // ====================
    // RTC and mtime
    // ====================
    // RTC divides the clock by two
    // mtime moves on the high RTC phase
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rtc   <= 1'b0;
            mtime <= '0;
        end else begin
            rtc <= ~rtc;
            if (rtc) mtime <= mtime + 64'd1;
        end
    end

    // ====================
    // Register writes
    // ====================
    // mtime and unknown offsets take the ack and drop the data
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            msip <= '0;
            for (int h = 0; h < HART_NUM; h++) mtimecmp[h] <= '1;
        end else if (wr_hit) begin
            for (int h = 0; h < HART_NUM; h++) begin
                if (ofs == MSIP_OFS + OFS_W'(4 * h) && req_i.sel[0]) begin
                    msip[h] <= req_i.dat[0];
                end
                // Low word
                if (ofs == MTIMECMP_OFS + OFS_W'(8 * h)) begin
                    mtimecmp[h][31:0] <= wb_merge(mtimecmp[h][31:0], req_i.dat, req_i.sel);
                end
                // High word
                if (ofs == MTIMECMP_OFS + OFS_W'(8 * h + 4)) begin
                    mtimecmp[h][63:32] <= wb_merge(mtimecmp[h][63:32], req_i.dat, req_i.sel);
                end
            end
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        for (int h = 0; h < HART_NUM; h++) begin
            if (ofs == MSIP_OFS + OFS_W'(4 * h))         rdata = {31'b0, msip[h]};
            if (ofs == MTIMECMP_OFS + OFS_W'(8 * h))     rdata = mtimecmp[h][31:0];
            if (ofs == MTIMECMP_OFS + OFS_W'(8 * h + 4)) rdata = mtimecmp[h][63:32];
        end
        if (ofs == MTIME_OFS)           rdata = mtime[31:0];
        if (ofs == MTIME_OFS + 12'h004) rdata = mtime[63:32];
    end

    // ====================
    // Reply and interrupts
    // ====================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            ack_q       <= 1'b0;
            timer_irq_o <= '0;
        end else begin
            ack_q <= req_hit;
            for (int h = 0; h < HART_NUM; h++) begin
                timer_irq_o[h] <= (mtime >= mtimecmp[h]);
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk_i) begin
        if (req_hit) rdata_q <= rdata;
    end

    // Software interrupt per hart follows msip
    assign ipi_o = msip;

    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;
    assign rsp_o.dat = rdata_q;

    a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_i)
        ack_q |=> !ack_q);

endmodule

//--- plic/soc_plic.sv
`timescale 1ns/100ps

module soc_plic #(
    parameter int HART_NUM   = 2,
    parameter int SOURCE_NUM = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  soc_pkg::wb_req_t      req_i,
    output soc_pkg::wb_rsp_t      rsp_o,
    input  logic [SOURCE_NUM-1:0] irq_src_i,
    output logic [2*HART_NUM-1:0] irq_target_o
);
    import soc_pkg::*;

    // Two contexts per hart
    localparam int TARGET_NUM = 2 * HART_NUM;
    localparam int ID_W       = $clog2(SOURCE_NUM + 1);
    localparam int TGT_W      = $clog2(TARGET_NUM);

    logic [SOURCE_NUM:1] src;
    logic [SOURCE_NUM:1] pending;
    logic [SOURCE_NUM:1] in_service;
    logic [PRIO_W-1:0]   prio   [1:SOURCE_NUM];
    logic [SOURCE_NUM:1] enable [TARGET_NUM];
    logic [PRIO_W-1:0]   thresh [TARGET_NUM];
    logic [ID_W-1:0]     best_id [TARGET_NUM];
    logic [OFS_W-1:0]    ofs;
    logic                ack_q;
    logic                req_hit;
    logic                claim_sel;
    logic [TGT_W-1:0]    claim_tgt;
    logic                claim_rd;
    logic                cmpl_wr;
    logic [ID_W-1:0]     claim_id;
    logic [ID_W-1:0]     cmpl_id;
    logic [DATA_W-1:0]   rdata;
    logic [DATA_W-1:0]   rdata_q;

    // Source bit 0 is id 1
    assign src     = irq_src_i;
    assign ofs     = req_i.adr[OFS_W-1:0];
    assign req_hit = req_i.cyc && req_i.stb && !ack_q;

    // ====================
    // Target arbitration
    // ====================
    // Strict compare keeps the lowest id on a tie,
    // starting at the threshold folds in the gate
    always_comb begin : best_sel
        logic [PRIO_W-1:0] best_pri;
        for (int t = 0; t < TARGET_NUM; t++) begin
            best_pri   = thresh[t];
            best_id[t] = '0;
            for (int i = 1; i <= SOURCE_NUM; i++) begin
                if (pending[i] && enable[t][i] && prio[i] > best_pri) begin
                    best_pri   = prio[i];
                    best_id[t] = ID_W'(i);
                end
            end
        end
    end

    // Claim register decode
    always_comb begin
        claim_sel = 1'b0;
        claim_tgt = '0;
        for (int t = 0; t < TARGET_NUM; t++) begin
            if (ofs == CLAIM_OFS + OFS_W'(8 * t)) begin
                claim_sel = 1'b1;
                claim_tgt = TGT_W'(t);
            end
        end
    end

    assign claim_rd = req_hit && !req_i.we && claim_sel;
    assign cmpl_wr  = req_hit && req_i.we && claim_sel;
    assign claim_id = best_id[claim_tgt];
    assign cmpl_id  = req_i.dat[ID_W-1:0];

    // ====================
    // Gateways
    // ====================
    // Level sources, blocked while the id is in service
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            pending    <= '0;
            in_service <= '0;
        end else begin
            for (int i = 1; i <= SOURCE_NUM; i++) begin
                if (src[i] && !in_service[i]) pending[i] <= 1'b1;
            end
            if (claim_rd && claim_id != '0) begin
                pending[claim_id]    <= 1'b0;
                in_service[claim_id] <= 1'b1;
            end
            // Out of range ids are ignored on complete
            if (cmpl_wr && cmpl_id != '0 && cmpl_id <= ID_W'(SOURCE_NUM)) begin
                in_service[cmpl_id] <= 1'b0;
            end
        end
    end

    // ====================
    // Config registers
    // ====================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 1; i <= SOURCE_NUM; i++) prio[i] <= '0;
            for (int t = 0; t < TARGET_NUM; t++) begin
                enable[t] <= '0;
                thresh[t] <= '0;
            end
        end else if (req_hit && req_i.we) begin
            for (int i = 1; i <= SOURCE_NUM; i++) begin
                if (ofs == PRIO_OFS + OFS_W'(4 * i)) prio[i] <= req_i.dat[PRIO_W-1:0];
            end
            for (int t = 0; t < TARGET_NUM; t++) begin
                if (ofs == ENABLE_OFS + OFS_W'(4 * t)) enable[t] <= req_i.dat[SOURCE_NUM:1];
                if (ofs == THRESH_OFS + OFS_W'(8 * t)) thresh[t] <= req_i.dat[PRIO_W-1:0];
            end
        end
    end

    // Read mux, claim returns the current best id
    always_comb begin
        rdata = '0;
        if (ofs == PEND_OFS) rdata = DATA_W'({pending, 1'b0});
        for (int i = 1; i <= SOURCE_NUM; i++) begin
            if (ofs == PRIO_OFS + OFS_W'(4 * i)) rdata = DATA_W'(prio[i]);
        end
        for (int t = 0; t < TARGET_NUM; t++) begin
            if (ofs == ENABLE_OFS + OFS_W'(4 * t)) rdata = DATA_W'({enable[t], 1'b0});
            if (ofs == THRESH_OFS + OFS_W'(8 * t)) rdata = DATA_W'(thresh[t]);
            if (ofs == CLAIM_OFS + OFS_W'(8 * t))  rdata = DATA_W'(best_id[t]);
        end
    end

    // ====================
    // Reply and outputs
    // ====================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            ack_q        <= 1'b0;
            irq_target_o <= '0;
        end else begin
            ack_q <= req_hit;
            for (int t = 0; t < TARGET_NUM; t++) begin
                irq_target_o[t] <= (best_id[t] != '0);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_hit) rdata_q <= rdata;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;
    assign rsp_o.dat = rdata_q;

    // Registered output must agree with the claim that follows it
    a_claim_nonzero: assert property (@(posedge clk_i) disable iff (!rst_i)
        (claim_rd && irq_target_o[claim_tgt]) |-> (claim_id != '0));

endmodule

//--- src/soc_gpio.sv
`timescale 1ns/100ps

module soc_gpio #(
    parameter int GPIO_W = 8
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  soc_pkg::wb_req_t  req_i,
    output soc_pkg::wb_rsp_t  rsp_o,
    input  logic [GPIO_W-1:0] sw_i,
    output logic [GPIO_W-1:0] led_o,
    output logic              irq_o
);
    import soc_pkg::*;

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] mask_q;
    logic [GPIO_W-1:0] sw_meta;
    logic [GPIO_W-1:0] sw_sync;
    logic [OFS_W-1:0]  ofs;
    logic              ack_q;
    logic              req_hit;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] rdata_q;

    assign ofs     = req_i.adr[OFS_W-1:0];
    assign req_hit = req_i.cyc && req_i.stb && !ack_q;

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            ack_q   <= 1'b0;
            out_q   <= '0;
            mask_q  <= '0;
            sw_meta <= '0;
            sw_sync <= '0;
            irq_o   <= 1'b0;
        end else begin
            ack_q <= req_hit;
            // Two stage switch sync
            sw_meta <= sw_i;
            sw_sync <= sw_meta;
            // Level irq from masked switches
            irq_o <= |(sw_sync & mask_q);
            if (req_hit && req_i.we) begin
                if (ofs == OUT_OFS) begin
                    out_q <= GPIO_W'(wb_merge(DATA_W'(out_q), req_i.dat, req_i.sel));
                end
                if (ofs == IRQ_MASK_OFS) begin
                    mask_q <= GPIO_W'(wb_merge(DATA_W'(mask_q), req_i.dat, req_i.sel));
                end
            end
        end
    end

    // IN is read-only
    always_comb begin
        case (ofs)
            OUT_OFS:      rdata = DATA_W'(out_q);
            IN_OFS:       rdata = DATA_W'(sw_sync);
            IRQ_MASK_OFS: rdata = DATA_W'(mask_q);
            default:      rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req_hit) rdata_q <= rdata;
    end

    assign led_o     = out_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;
    assign rsp_o.dat = rdata_q;

endmodule

//--- src/soc_top.sv
`timescale 1ns/100ps

module soc_top #(
    parameter int HART_NUM   = 2,
    parameter int SOURCE_NUM = 8,
    parameter int GPIO_W     = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  soc_pkg::wb_req_t      bus_req_i,
    output soc_pkg::wb_rsp_t      bus_rsp_o,
    input  logic [SOURCE_NUM-2:0] irq_src_i,
    input  logic [GPIO_W-1:0]     sw_i,
    output logic [GPIO_W-1:0]     led_o,
    output logic [HART_NUM-1:0]   timer_irq_o,
    output logic [HART_NUM-1:0]   ipi_o,
    output logic [2*HART_NUM-1:0] irq_target_o
);
    import soc_pkg::*;

    wb_req_t               clint_req;
    wb_req_t               plic_req;
    wb_req_t               gpio_req;
    wb_rsp_t               clint_rsp;
    wb_rsp_t               plic_rsp;
    wb_rsp_t               gpio_rsp;
    logic                  gpio_irq;
    logic [SOURCE_NUM-1:0] plic_src;

    // GPIO is id 1, external lines follow
    assign plic_src = {irq_src_i, gpio_irq};

    // ====================
    // Bus decode
    // ====================
    wb_addr_decode u_decode (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (bus_req_i),
        .rsp_o       (bus_rsp_o),
        .clint_req_o (clint_req),
        .plic_req_o  (plic_req),
        .gpio_req_o  (gpio_req),
        .clint_rsp_i (clint_rsp),
        .plic_rsp_i  (plic_rsp),
        .gpio_rsp_i  (gpio_rsp)
    );

    // ====================
    // Peripherals
    // ====================
    soc_clint #(
        .HART_NUM    (HART_NUM)
    ) u_clint (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (clint_req),
        .rsp_o       (clint_rsp),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    soc_plic #(
        .HART_NUM     (HART_NUM),
        .SOURCE_NUM   (SOURCE_NUM)
    ) u_plic (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (plic_req),
        .rsp_o        (plic_rsp),
        .irq_src_i    (plic_src),
        .irq_target_o (irq_target_o)
    );

    soc_gpio #(
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (gpio_req),
        .rsp_o  (gpio_rsp),
        .sw_i   (sw_i),
        .led_o  (led_o),
        .irq_o  (gpio_irq)
    );

endmodule

//--- dv/tb_soc_tests.svh
`ifndef TB_SOC_TESTS_SVH
`define TB_SOC_TESTS_SVH

// ====================
// Wait helpers
// ====================
task automatic wait_target(input int tgt, input logic level);
    int n;
    n = 0;
    while (irq_target_o[tgt] !== level && n < IRQ_TIMEOUT) begin
        next_cycle();
        n++;
    end
    if (irq_target_o[tgt] !== level) begin
        report_error($sformatf("PLIC target %0d did not go to %0b in time", tgt, level));
    end
endtask

task automatic wait_timer(input int h, input logic level);
    int n;
    n = 0;
    while (timer_irq_o[h] !== level && n < IRQ_TIMEOUT) begin
        next_cycle();
        n++;
    end
    if (timer_irq_o[h] !== level) begin
        report_error($sformatf("timer interrupt of hart %0d did not go to %0b in time", h, level));
    end
endtask

// Switches pass two sync flops, so poll IN
task automatic poll_switches(input logic [GPIO_W-1:0] expected);
    logic [DATA_W-1:0] rd;
    int                n;
    n = 0;
    wb_read(GPIO_BASE + ADDR_W'(IN_OFS), rd);
    while (rd !== DATA_W'(expected) && n < POLL_LIMIT) begin
        wb_read(GPIO_BASE + ADDR_W'(IN_OFS), rd);
        n++;
    end
    check_value("gpio IN", rd, DATA_W'(expected));
endtask

// mtime as low word then high word
task automatic read_mtime(output logic [63:0] t);
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    wb_read(CLINT_BASE + ADDR_W'(MTIME_OFS), lo);
    wb_read(CLINT_BASE + ADDR_W'(MTIME_OFS + 4), hi);
    t = {hi, lo};
endtask

// ====================
// Directed tests
// ====================
task automatic test_reset_state();
    logic [DATA_W-1:0] rd;
    check_value("led_o", led_o, 0);
    check_value("timer_irq_o", timer_irq_o, 0);
    check_value("ipi_o", ipi_o, 0);
    check_value("irq_target_o", irq_target_o, 0);
    // mtimecmp comes out of reset as all ones
    for (int h = 0; h < HART_NUM; h++) begin
        wb_read(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h), rd);
        check_value($sformatf("mtimecmp[%0d] low", h), rd, 32'hFFFF_FFFF);
        wb_read(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h + 4), rd);
        check_value($sformatf("mtimecmp[%0d] high", h), rd, 32'hFFFF_FFFF);
    end
endtask

task automatic test_gpio();
    logic [31:0]       r;
    logic [DATA_W-1:0] rd;
    logic [GPIO_W-1:0] pat;
    int                bit_n;
    // LED register
    next_random(r);
    pat = r[GPIO_W-1:0];
    wb_write(GPIO_BASE + ADDR_W'(OUT_OFS), DATA_W'(pat));
    check_value("led_o", led_o, pat);
    wb_read(GPIO_BASE + ADDR_W'(OUT_OFS), rd);
    check_value("gpio OUT", rd, DATA_W'(pat));
    // Switch pattern
    next_random(r);
    sw_i = r[GPIO_W-1:0];
    poll_switches(r[GPIO_W-1:0]);
    sw_i = '0;
    poll_switches('0);
    // Switch interrupt through PLIC id 1 to target 0
    bit_n = int'(r[15:13]) % GPIO_W;
    wb_write(PLIC_BASE + ADDR_W'(PRIO_OFS + 4), 32'd5);
    wb_write(PLIC_BASE + ADDR_W'(ENABLE_OFS), 32'h2);
    wb_write(PLIC_BASE + ADDR_W'(THRESH_OFS), 32'd0);
    wb_write(GPIO_BASE + ADDR_W'(IRQ_MASK_OFS), DATA_W'(1) << bit_n);
    check_value("irq_target_o[0]", irq_target_o[0], 0);
    sw_i[bit_n] = 1'b1;
    wait_target(0, 1'b1);
    wb_read(PLIC_BASE + ADDR_W'(CLAIM_OFS), rd);
    check_value("claim target 0", rd, 1);
    // Quiet the switch, then complete and unconfigure
    sw_i = '0;
    wb_write(GPIO_BASE + ADDR_W'(IRQ_MASK_OFS), 32'd0);
    wb_write(PLIC_BASE + ADDR_W'(CLAIM_OFS), 32'd1);
    wb_write(PLIC_BASE + ADDR_W'(ENABLE_OFS), 32'd0);
    wb_write(PLIC_BASE + ADDR_W'(PRIO_OFS + 4), 32'd0);
    check_value("irq_target_o", irq_target_o, 0);
endtask

task automatic test_clint();
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] cmp;
    // Software interrupt per hart
    for (int h = 0; h < HART_NUM; h++) begin
        wb_write(CLINT_BASE + ADDR_W'(MSIP_OFS + 4 * h), 32'd1);
        check_value("ipi_o", ipi_o, HART_NUM'(1) << h);
        wb_write(CLINT_BASE + ADDR_W'(MSIP_OFS + 4 * h), 32'd0);
        check_value("ipi_o", ipi_o, 0);
    end
    // mtime never runs backwards
    read_mtime(t0);
    read_mtime(t1);
    check_value("mtime non-decreasing", t1 >= t0, 1);
    // Timer compare a little ahead of mtime
    for (int h = 0; h < HART_NUM; h++) begin
        read_mtime(t0);
        cmp = t0 + 64'd20;
        wb_write(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h), cmp[31:0]);
        wb_write(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h + 4), cmp[63:32]);
        check_value("timer_irq_o", timer_irq_o, 0);
        wait_timer(h, 1'b1);
        check_value("timer_irq_o", timer_irq_o, HART_NUM'(1) << h);
        wb_write(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h), 32'hFFFF_FFFF);
        wb_write(CLINT_BASE + ADDR_W'(MTIMECMP_OFS + 8 * h + 4), 32'hFFFF_FFFF);
        wait_timer(h, 1'b0);
    end
endtask

task automatic test_plic();
    logic [PRIO_W-1:0]     prio_model [SOURCE_NUM+1];
    logic [SOURCE_NUM-2:0] active;
    logic [31:0]           r;
    logic [DATA_W-1:0]     rd;
    logic [ADDR_W-1:0]     claim_adr;
    int                    tgt;
    int                    best;
    int                    best_pri;
    tgt       = 1;
    claim_adr = PLIC_BASE + ADDR_W'(CLAIM_OFS + 8 * tgt);
    // Random nonzero priorities for the external ids
    for (int id = 2; id <= SOURCE_NUM; id++) begin
        next_random(r);
        prio_model[id] = PRIO_W'(r % 7 + 1);
        wb_write(PLIC_BASE + ADDR_W'(PRIO_OFS + 4 * id), DATA_W'(prio_model[id]));
    end
    wb_write(PLIC_BASE + ADDR_W'(ENABLE_OFS + 4 * tgt),
             DATA_W'({(SOURCE_NUM-1){1'b1}}) << 2);
    // At least two sources up at once
    next_random(r);
    active = r[SOURCE_NUM-2:0];
    if ($countones(active) < 2) active = active | (SOURCE_NUM-1)'(3);
    irq_src_i = active;
    wait_target(tgt, 1'b1);
    // Claim order from the priority model
    while (active != 0) begin
        best     = 0;
        best_pri = 0;
        for (int id = 2; id <= SOURCE_NUM; id++) begin
            if (active[id-2] && int'(prio_model[id]) > best_pri) begin
                best_pri = int'(prio_model[id]);
                best     = id;
            end
        end
        wb_read(claim_adr, rd);
        check_value($sformatf("claim target %0d", tgt), rd, best);
        active[best-2] = 1'b0;
        irq_src_i      = active;
        wb_write(claim_adr, DATA_W'(best));
    end
    wb_read(claim_adr, rd);
    check_value("claim with nothing pending", rd, 0);
    check_value("irq_target_o", irq_target_o, 0);
    // Threshold at the top priority masks everything
    next_random(r);
    irq_src_i = r[SOURCE_NUM-2:0] | (SOURCE_NUM-1)'(1);
    wait_target(tgt, 1'b1);
    wb_write(PLIC_BASE + ADDR_W'(THRESH_OFS + 8 * tgt), 32'd7);
    wait_target(tgt, 1'b0);
    wb_read(claim_adr, rd);
    check_value("claim above threshold", rd, 0);
    irq_src_i = '0;
    wb_write(PLIC_BASE + ADDR_W'(ENABLE_OFS + 4 * tgt), 32'd0);
endtask

task automatic test_unmapped();
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rd;
    logic [31:0]       r;
    logic [ADDR_W-1:0] adr;
    // Anywhere from 0x3000 up
    next_random(r);
    adr = 16'h3000 + ADDR_W'(r % 32'hD000);
    wb_access(1'b0, adr, '0, ack, err, rd);
    check_value("unmapped read err", err, 1);
    check_value("unmapped read ack", ack, 0);
    check_value("unmapped read data", rd, 0);
    wb_access(1'b1, 16'hFFFC, r, ack, err, rd);
    check_value("unmapped write err", err, 1);
    check_value("unmapped write ack", ack, 0);
    // Mapped access still works afterwards
    wb_read(GPIO_BASE + ADDR_W'(IRQ_MASK_OFS), rd);
    check_value("gpio IRQ_MASK", rd, 0);
endtask

`endif

//--- dv/tb_soc_top.sv
`timescale 1ns/100ps

module tb_soc_top;
    import soc_pkg::*;

    // ====================
    // Configuration
    // ====================
    localparam int HART_NUM   = 2;
    localparam int SOURCE_NUM = 8;
    localparam int GPIO_W     = 8;

    // 4 KiB windows of the address map
    localparam logic [ADDR_W-1:0] CLINT_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] PLIC_BASE  = 16'h1000;
    localparam logic [ADDR_W-1:0] GPIO_BASE  = 16'h2000;

    // Wait limits in clock cycles or bus accesses
    localparam int BUS_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 200;
    localparam int POLL_LIMIT  = 20;

    logic                  clk_i;
    logic                  rst_i;
    wb_req_t               bus_req_i;
    wb_rsp_t               bus_rsp_o;
    logic [SOURCE_NUM-2:0] irq_src_i;
    logic [GPIO_W-1:0]     sw_i;
    logic [GPIO_W-1:0]     led_o;
    logic [HART_NUM-1:0]   timer_irq_o;
    logic [HART_NUM-1:0]   ipi_o;
    logic [2*HART_NUM-1:0] irq_target_o;

    // Random generator state
    logic [31:0]           rng_state;

    soc_top #(
        .HART_NUM     (HART_NUM),
        .SOURCE_NUM   (SOURCE_NUM),
        .GPIO_W       (GPIO_W)
    ) u_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_req_i    (bus_req_i),
        .bus_rsp_o    (bus_rsp_o),
        .irq_src_i    (irq_src_i),
        .sw_i         (sw_i),
        .led_o        (led_o),
        .timer_irq_o  (timer_irq_o),
        .ipi_o        (ipi_o),
        .irq_target_o (irq_target_o)
    );

    // 10 ns clock
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ====================
    // Error handling
    // ====================
    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        end_with_failure();
    endtask

    // Compare one observed value with its expected value
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t signal %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // ====================
    // Random numbers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r         = rng_state;
    endtask

    // ====================
    // Bus access
    // ====================
    // Drive and sample 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // One Wishbone classic access, held until ack or err
    task automatic wb_access(input logic write_en, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output logic ack,
                             output logic err, output logic [DATA_W-1:0] rdat);
        int   n;
        logic done;
        bus_req_i.cyc = 1'b1;
        bus_req_i.stb = 1'b1;
        bus_req_i.we  = write_en;
        bus_req_i.sel = '1;
        bus_req_i.adr = adr;
        bus_req_i.dat = wdat;
        n    = 0;
        done = 1'b0;
        while (!done && n < BUS_TIMEOUT) begin
            next_cycle();
            done = bus_rsp_o.ack || bus_rsp_o.err;
            n++;
        end
        if (!done) begin
            report_error($sformatf("no bus reply from address 0x%0h", adr));
        end
        // Reply data only valid in the ack cycle
        ack       = bus_rsp_o.ack;
        err       = bus_rsp_o.err;
        rdat      = bus_rsp_o.dat;
        bus_req_i = '0;
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat);
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] rdat;
        wb_access(1'b1, adr, wdat, ack, err, rdat);
        if (err) begin
            report_error($sformatf("unexpected bus error on write to 0x%0h", adr));
        end
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
        logic ack;
        logic err;
        wb_access(1'b0, adr, '0, ack, err, rdat);
        if (err) begin
            report_error($sformatf("unexpected bus error on read from 0x%0h", adr));
        end
    endtask

    `include "tb_soc_tests.svh"

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst_i     = 1'b0;
        bus_req_i = '0;
        irq_src_i = '0;
        sw_i      = '0;
        rng_state = 32'd99;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        test_reset_state();
        test_gpio();
        test_clint();
        test_plic();
        test_unmapped();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+dv
common/soc_pkg.sv
src/wb_addr_decode.sv
clint/soc_clint.sv
plic/soc_plic.sv
src/soc_gpio.sv
src/soc_top.sv
dv/tb_soc_top.sv
